/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [6:0] {
        OPC_R     = 7'b0110011,
        OPC_I     = 7'b0010011,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_L     = 7'b0000011,
        OPC_S     = 7'b0100011,
        OPC_B     = 7'b1100011,
        OPC_JAL   = 7'b1101111
    } opcode_e;

    // The opcode is kept as raw bits so any fetched word fits the layout.
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_optr_e;

    // Load and store widths use the funct3 encoding directly.
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_W  = 3'b010,
        LS_BU = 3'b100
    } ls_width_e;

endpackage

/* logic/pipe_pkg.sv */
package pipe_pkg;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_addr_t addr;
        rv_isa_pkg::data_t     val;
    } fwd_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::data_t     opnd_1;
        rv_isa_pkg::data_t     opnd_2;
        rv_isa_pkg::data_t     st_val;
        rv_isa_pkg::data_t     pc;
        rv_isa_pkg::data_t     br_offset;
        rv_isa_pkg::alu_optr_e alu_optr;
        logic                  is_branch;
        logic                  branch_ne;
        logic                  is_jal;
        logic                  reg_we;
        rv_isa_pkg::reg_addr_t rd;
        logic                  mem_rd_en;
        logic                  mem_wr_en;
        rv_isa_pkg::ls_width_e ls_width;
    } dec_ex_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::data_t     result;
        rv_isa_pkg::data_t     st_val;
        rv_isa_pkg::reg_addr_t rd;
        logic                  reg_we;
        logic                  mem_rd_en;
        logic                  mem_wr_en;
        rv_isa_pkg::ls_width_e ls_width;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::data_t     val;
    } retire_t;

    typedef enum logic {
        FS_RUN,
        FS_HOLD
    } fetch_stall_e;

endpackage

/* logic/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  rv_isa_pkg::reg_addr_t i_rd_addr_1,
    input  rv_isa_pkg::reg_addr_t i_rd_addr_2,
    input  logic                  i_wr_en,
    input  rv_isa_pkg::reg_addr_t i_wr_addr,
    input  rv_isa_pkg::data_t     i_wr_val,
    output rv_isa_pkg::data_t     o_val_1,
    output rv_isa_pkg::data_t     o_val_2
);
    import rv_isa_pkg::*;

    data_t regs [1:31];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wr_en && (i_wr_addr != '0))
        begin
            regs[i_wr_addr] <= i_wr_val;
        end
    end

    // There is no storage behind x0.
    assign o_val_1 = (i_rd_addr_1 == '0) ? '0 : regs[i_rd_addr_1];
    assign o_val_2 = (i_rd_addr_2 == '0) ? '0 : regs[i_rd_addr_2];

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  pipe_pkg::fetch_stall_e i_stall,
    input  logic                   i_redirect,
    input  rv_isa_pkg::data_t      i_target,
    input  rv_isa_pkg::instr_t     i_instr,
    output rv_isa_pkg::data_t      o_imem_addr,
    output rv_isa_pkg::data_t      o_pc,
    output rv_isa_pkg::instr_t     o_instr,
    output logic                   o_valid
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    data_t pc;
    logic  advance;

    assign o_imem_addr = pc;
    assign advance     = !i_redirect && (i_stall == FS_RUN);

    // A redirect wins over a hold and drops the word fetched this cycle.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            pc      <= RESET_PC;
            o_valid <= 1'b0;
        end
        else if (i_redirect)
        begin
            pc      <= i_target;
            o_valid <= 1'b0;
        end
        else if (advance)
        begin
            pc      <= pc + 32'd4;
            o_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (advance)
        begin
            o_pc    <= pc;
            o_instr <= i_instr;
        end
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  rv_isa_pkg::data_t      i_pc,
    input  rv_isa_pkg::instr_t     i_instr,
    input  logic                   i_valid,
    input  logic                   i_flush,
    input  pipe_pkg::fwd_t         i_ex_fwd,
    input  pipe_pkg::fwd_t         i_mem_fwd,
    input  pipe_pkg::fwd_t         i_wb_fwd,
    input  pipe_pkg::retire_t      i_wr,
    output pipe_pkg::dec_ex_t      o_dec,
    output pipe_pkg::fetch_stall_e o_stall
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    opcode_e   opc;
    data_t     iw;
    data_t     rf_val_1;
    data_t     rf_val_2;
    data_t     reg_val_1;
    data_t     reg_val_2;
    data_t     imm_i;
    data_t     imm_s;
    data_t     imm_b;
    data_t     imm_u;
    data_t     imm_j;
    data_t     imm_val;
    alu_optr_e alu_optr;
    logic      known;
    logic      use_rs1;
    logic      use_rs2;
    logic      reg_we;
    logic      hazard;
    logic      stall;
    logic      prev_stall;
    dec_ex_t   dec_d;

    // Youngest producer wins; x0 is never forwarded.
    function automatic data_t fwd_pick(reg_addr_t addr, data_t rf_val,
                                       fwd_t ex_f, fwd_t mem_f, fwd_t wb_f);
        data_t val;
        if (addr == '0)
            val = '0;
        else if (ex_f.valid && (ex_f.addr == addr))
            val = ex_f.val;
        else if (mem_f.valid && (mem_f.addr == addr))
            val = mem_f.val;
        else if (wb_f.valid && (wb_f.addr == addr))
            val = wb_f.val;
        else
            val = rf_val;
        return val;
    endfunction

    assign opc   = opcode_e'(i_instr.opcode);
    assign iw    = i_instr;
    assign imm_i = {{20{iw[31]}}, iw[31:20]};
    assign imm_s = {{20{iw[31]}}, iw[31:25], iw[11:7]};
    assign imm_b = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
    assign imm_u = {iw[31:12], 12'b0};
    assign imm_j = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};

    assign use_rs1 = (opc == OPC_R) || (opc == OPC_I) || (opc == OPC_L) ||
                     (opc == OPC_S) || (opc == OPC_B);
    assign use_rs2 = (opc == OPC_R) || (opc == OPC_S) || (opc == OPC_B);
    assign reg_we  = (opc == OPC_R) || (opc == OPC_I) || (opc == OPC_LUI) ||
                     (opc == OPC_AUIPC) || (opc == OPC_L) || (opc == OPC_JAL);

    always_comb
    begin
        known    = 1'b1;
        alu_optr = ALU_ADD;
        imm_val  = imm_i;
        case (opc)
            OPC_R:
            begin
                case (i_instr.funct3)
                    3'b000:  alu_optr = i_instr.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_optr = ALU_SLT;
                    3'b100:  alu_optr = ALU_XOR;
                    3'b110:  alu_optr = ALU_OR;
                    3'b111:  alu_optr = ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            OPC_I:     known = (i_instr.funct3 == 3'b000);
            OPC_LUI:
            begin
                imm_val  = imm_u;
                alu_optr = ALU_PASS_B;
            end
            OPC_AUIPC: imm_val = imm_u;
            OPC_L:     known = (i_instr.funct3 == LS_B) || (i_instr.funct3 == LS_W) ||
                               (i_instr.funct3 == LS_BU);
            OPC_S:
            begin
                imm_val = imm_s;
                known   = (i_instr.funct3 == LS_B) || (i_instr.funct3 == LS_W);
            end
            OPC_B:
            begin
                imm_val = imm_b;
                known   = (i_instr.funct3[2:1] == 2'b00);
            end
            OPC_JAL:   imm_val = imm_j;
            default:   known = 1'b0;
        endcase
    end

    assign reg_val_1 = fwd_pick(i_instr.rs1, rf_val_1, i_ex_fwd, i_mem_fwd, i_wb_fwd);
    assign reg_val_2 = fwd_pick(i_instr.rs2, rf_val_2, i_ex_fwd, i_mem_fwd, i_wb_fwd);

    // The load now in execute has no value yet, so its consumer waits one cycle.
    assign hazard  = i_valid && o_dec.valid && o_dec.mem_rd_en && o_dec.reg_we &&
                     ((use_rs1 && (o_dec.rd == i_instr.rs1)) ||
                      (use_rs2 && (o_dec.rd == i_instr.rs2)));
    assign stall   = hazard && !prev_stall;
    assign o_stall = stall ? FS_HOLD : FS_RUN;

    always_comb
    begin
        dec_d.valid     = i_valid && known && !stall && !i_flush;
        dec_d.opnd_1    = (opc == OPC_AUIPC) ? i_pc : reg_val_1;
        dec_d.opnd_2    = (use_rs2 && (opc != OPC_S)) ? reg_val_2 : imm_val;
        dec_d.st_val    = reg_val_2;
        dec_d.pc        = i_pc;
        dec_d.br_offset = imm_val;
        dec_d.alu_optr  = alu_optr;
        dec_d.is_branch = (opc == OPC_B);
        dec_d.branch_ne = i_instr.funct3[0];
        dec_d.is_jal    = (opc == OPC_JAL);
        dec_d.reg_we    = reg_we && (i_instr.rd != '0);
        dec_d.rd        = i_instr.rd;
        dec_d.mem_rd_en = (opc == OPC_L);
        dec_d.mem_wr_en = (opc == OPC_S);
        dec_d.ls_width  = ls_width_e'(i_instr.funct3);
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_dec      <= '0;
            prev_stall <= 1'b0;
        end
        else
        begin
            o_dec      <= dec_d;
            prev_stall <= stall;
        end
    end

    reg_file u_reg_file (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rd_addr_1 (i_instr.rs1),
        .i_rd_addr_2 (i_instr.rs2),
        .i_wr_en     (i_wr.valid),
        .i_wr_addr   (i_wr.rd),
        .i_wr_val    (i_wr.val),
        .o_val_1     (rf_val_1),
        .o_val_2     (rf_val_2)
    );

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  pipe_pkg::dec_ex_t i_dec,
    output pipe_pkg::ex_mem_t o_ex,
    output pipe_pkg::fwd_t    o_fwd,
    output logic              o_redirect,
    output rv_isa_pkg::data_t o_target
);
    import rv_isa_pkg::*;

    data_t alu_out;
    data_t result;
    logic  taken;

    always_comb
    begin
        case (i_dec.alu_optr)
            ALU_ADD:    alu_out = i_dec.opnd_1 + i_dec.opnd_2;
            ALU_SUB:    alu_out = i_dec.opnd_1 - i_dec.opnd_2;
            ALU_AND:    alu_out = i_dec.opnd_1 & i_dec.opnd_2;
            ALU_OR:     alu_out = i_dec.opnd_1 | i_dec.opnd_2;
            ALU_XOR:    alu_out = i_dec.opnd_1 ^ i_dec.opnd_2;
            ALU_SLT:    alu_out = {31'b0, $signed(i_dec.opnd_1) < $signed(i_dec.opnd_2)};
            ALU_PASS_B: alu_out = i_dec.opnd_2;
            default:    alu_out = '0;
        endcase
    end

    // BNE inverts the equality test.
    assign taken      = i_dec.is_branch && ((i_dec.opnd_1 == i_dec.opnd_2) != i_dec.branch_ne);
    assign result     = i_dec.is_jal ? (i_dec.pc + 32'd4) : alu_out;
    assign o_target   = i_dec.pc + i_dec.br_offset;
    assign o_redirect = i_dec.valid && (i_dec.is_jal || taken);

    assign o_fwd.valid = i_dec.valid && i_dec.reg_we && !i_dec.mem_rd_en;
    assign o_fwd.addr  = i_dec.rd;
    assign o_fwd.val   = result;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_ex <= '0;
        end
        else
        begin
            o_ex.valid     <= i_dec.valid;
            o_ex.result    <= result;
            o_ex.st_val    <= i_dec.st_val;
            o_ex.rd        <= i_dec.rd;
            o_ex.reg_we    <= i_dec.reg_we;
            o_ex.mem_rd_en <= i_dec.mem_rd_en;
            o_ex.mem_wr_en <= i_dec.mem_wr_en;
            o_ex.ls_width  <= i_dec.ls_width;
        end
    end

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  pipe_pkg::ex_mem_t i_ex,
    output pipe_pkg::fwd_t    o_fwd,
    output pipe_pkg::retire_t o_wb
);
    import rv_isa_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    data_t           dmem [DMEM_WORDS];
    logic [AW-1:0]   word_idx;
    logic [1:0]      lane;
    logic [7:0]      rd_byte;
    data_t           rd_word;
    data_t           ld_val;
    data_t           wb_val;

    assign word_idx = i_ex.result[AW+1:2];
    assign lane     = i_ex.result[1:0];

    always_ff @(posedge i_clk)
    begin
        if (i_ex.valid && i_ex.mem_wr_en)
        begin
            if (i_ex.ls_width == LS_B)
                dmem[word_idx][{lane, 3'b000} +: 8] <= i_ex.st_val[7:0];
            else
                dmem[word_idx] <= i_ex.st_val;
        end
    end

    assign rd_word = dmem[word_idx];
    assign rd_byte = rd_word[{lane, 3'b000} +: 8];

    always_comb
    begin
        case (i_ex.ls_width)
            LS_B:    ld_val = {{24{rd_byte[7]}}, rd_byte};
            LS_BU:   ld_val = {24'b0, rd_byte};
            default: ld_val = rd_word;
        endcase
    end

    assign wb_val = i_ex.mem_rd_en ? ld_val : i_ex.result;

    assign o_fwd.valid = i_ex.valid && i_ex.reg_we;
    assign o_fwd.addr  = i_ex.rd;
    assign o_fwd.val   = wb_val;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_wb <= '0;
        end
        else
        begin
            o_wb.valid <= i_ex.valid && i_ex.reg_we && (i_ex.rd != '0);
            o_wb.rd    <= i_ex.rd;
            o_wb.val   <= wb_val;
        end
    end

endmodule

/* logic/core_top.sv */
`timescale 1ns/100ps

module core_top #(
    parameter int          DMEM_WORDS = 64,
    parameter logic [31:0] RESET_PC   = 32'h0
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    output rv_isa_pkg::data_t  o_imem_addr,
    input  rv_isa_pkg::instr_t i_imem_data,
    output pipe_pkg::retire_t  o_retire
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    data_t        fd_pc;
    data_t        ex_target;
    instr_t       fd_instr;
    logic         fd_valid;
    logic         ex_redirect;
    fetch_stall_e dec_stall;
    dec_ex_t      dec_ex;
    ex_mem_t      ex_mem;
    fwd_t         ex_fwd;
    fwd_t         mem_fwd;
    fwd_t         wb_fwd;
    retire_t      wb;

    // The writeback record doubles as the oldest forwarding source.
    assign wb_fwd.valid = wb.valid;
    assign wb_fwd.addr  = wb.rd;
    assign wb_fwd.val   = wb.val;
    assign o_retire     = wb;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch_stage (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (dec_stall),
        .i_redirect  (ex_redirect),
        .i_target    (ex_target),
        .i_instr     (i_imem_data),
        .o_imem_addr (o_imem_addr),
        .o_pc        (fd_pc),
        .o_instr     (fd_instr),
        .o_valid     (fd_valid)
    );

    decode_stage u_decode_stage (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_pc      (fd_pc),
        .i_instr   (fd_instr),
        .i_valid   (fd_valid),
        .i_flush   (ex_redirect),
        .i_ex_fwd  (ex_fwd),
        .i_mem_fwd (mem_fwd),
        .i_wb_fwd  (wb_fwd),
        .i_wr      (wb),
        .o_dec     (dec_ex),
        .o_stall   (dec_stall)
    );

    execute_stage u_execute_stage (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_dec      (dec_ex),
        .o_ex       (ex_mem),
        .o_fwd      (ex_fwd),
        .o_redirect (ex_redirect),
        .o_target   (ex_target)
    );

    mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem_stage (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ex    (ex_mem),
        .o_fwd   (mem_fwd),
        .o_wb    (wb)
    );

endmodule

/* sim/core_props.sv */
`timescale 1ns/100ps

module core_props (
    input logic                   i_clk,
    input logic                   i_rst_n,
    input pipe_pkg::retire_t      i_retire,
    input pipe_pkg::fetch_stall_e i_stall
);
    import pipe_pkg::*;

    int fail_cnt = 0;

    a_retire_idle: assert property (@(posedge i_clk) !i_rst_n |=> !i_retire.valid)
        else
        begin
            fail_cnt++;
            $error("retire port valid in the cycle after a reset cycle");
        end

    a_retire_rd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                  i_retire.valid |-> (i_retire.rd != '0))
        else
        begin
            fail_cnt++;
            $error("valid retire record names register x0");
        end

    // A load-use stall lasts exactly one cycle.
    a_stall_once: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                   (i_stall == FS_HOLD) |=> (i_stall == FS_RUN))
        else
        begin
            fail_cnt++;
            $error("fetch hold lasted two consecutive cycles");
        end

endmodule

bind core_top core_props u_core_props (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_retire (o_retire),
    .i_stall  (dec_stall)
);

/* sim/core_tb.sv */
`timescale 1ns/100ps

module core_tb;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int IMEM_WORDS   = 64;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 20;

    logic    clk = 1'b0;
    logic    rst_n;
    data_t   imem_addr;
    instr_t  imem_data;
    retire_t retire;

    data_t   imem [IMEM_WORDS];
    retire_t exp_q [$];
    int      prog_words   = 0;
    int      exp_idx      = 0;
    int      mismatch_cnt = 0;
    int      extra_cnt    = 0;
    int      addr_cnt     = 0;
    int      setup_cnt    = 0;
    int      cycles       = 0;
    int      cycle_limit  = 0;

    core_top #(
        .DMEM_WORDS (64),
        .RESET_PC   (32'h0)
    ) u_core_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .o_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_retire    (retire)
    );

    always #10 clk = ~clk;

    // The instruction memory answers in the same cycle as the address.
    assign imem_data = imem[imem_addr[7:2]];

    task automatic load_trace();
        int               fd;
        int               code;
        logic [7:0]       tag;
        data_t            word;
        reg_addr_t        rd;
        data_t            val;
        retire_t          rec;
        logic [8*160-1:0] rest;
        fd = $fopen("sim/core_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the trace file sim/core_trace.txt");
            setup_cnt++;
        end
        else
        begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1)
            begin
                case (tag)
                    "P":
                    begin
                        code = $fscanf(fd, "%h", word);
                        if ((code != 1) || (prog_words >= IMEM_WORDS))
                        begin
                            $display("Bad or surplus program word in the trace file");
                            setup_cnt++;
                        end
                        else
                        begin
                            imem[prog_words] = word;
                            prog_words++;
                        end
                    end
                    "R":
                    begin
                        code = $fscanf(fd, "%h %h", rd, val);
                        if (code != 2)
                        begin
                            $display("Bad retire record in the trace file");
                            setup_cnt++;
                        end
                        else
                        begin
                            rec.valid = 1'b1;
                            rec.rd    = rd;
                            rec.val   = val;
                            exp_q.push_back(rec);
                        end
                    end
                    "#": ;
                    default:
                    begin
                        $display("Unknown line tag in the trace file");
                        setup_cnt++;
                    end
                endcase
                code = $fgets(rest, fd);
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp, input int idx);
        if (got.rd != exp.rd)
        begin
            $display("MISMATCH o_retire.rd at record %0d: got %h expected %h",
                     idx, got.rd, exp.rd);
            mismatch_cnt++;
        end
        if (got.val != exp.val)
        begin
            $display("MISMATCH o_retire.val at record %0d: got %h expected %h",
                     idx, got.val, exp.val);
            mismatch_cnt++;
        end
    endtask

    // The closing self jump lets fetch run two words past it before the redirect.
    task automatic check_fetch_addr(input data_t addr);
        if ((addr[1:0] != 2'b00) || (addr >= (prog_words + 2) * 4))
        begin
            $display("Instruction fetch address %h lies outside the program", addr);
            addr_cnt++;
        end
    endtask

    function automatic int missing_count();
        return (exp_idx < exp_q.size()) ? (exp_q.size() - exp_idx) : 0;
    endfunction

    function automatic int total_errors();
        return mismatch_cnt + extra_cnt + addr_cnt + setup_cnt + missing_count() +
               u_core_top.u_core_props.fail_cnt;
    endfunction

    task automatic print_summary();
        $display(
            "Summary: %0d mismatches, %0d extra, %0d missing, %0d fetch, %0d setup, %0d assert",
            mismatch_cnt, extra_cnt, missing_count(), addr_cnt, setup_cnt,
            u_core_top.u_core_props.fail_cnt);
    endtask

    // Retire records change on the rising edge, so they are read on the falling one.
    always @(negedge clk)
    begin
        if (rst_n)
            check_fetch_addr(imem_addr);
        if (rst_n && retire.valid)
        begin
            if (exp_idx < exp_q.size())
                check_retire(retire, exp_q[exp_idx], exp_idx);
            else
            begin
                $display("Extra retirement beyond the expected list: rd %h value %h",
                         retire.rd, retire.val);
                extra_cnt++;
            end
            exp_idx++;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit))
        begin
            $display("Timeout after %0d cycles with %0d of %0d expected retirements seen",
                     cycles, exp_idx, exp_q.size());
            print_summary();
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        rst_n = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++)
        begin
            imem[i] = {i[15:0], ~i[15:0]};
        end
        load_trace();
        if ((prog_words == 0) || (exp_q.size() == 0))
        begin
            $display("The trace file holds no program or no expected retirements");
            setup_cnt++;
        end
        cycle_limit = prog_words * 20 + 100;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        while ((exp_idx < exp_q.size()) && (setup_cnt == 0))
        begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        print_summary();
        if (total_errors() == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* sim/core_trace.txt */
# Columns: P <instruction word in hex> [assembly note], or R <rd in hex> <value in hex>
# for each expected retirement in order. Text after the fields of a line is ignored.
P 00500093 addi x1, x0, 5
P 00308113 addi x2, x1, 3
P 002081b3 add x3, x1, x2
P 40118233 sub x4, x3, x1
P fff00313 addi x6, x0, -1
P 001323b3 slt x7, x6, x1
P 0061c433 xor x8, x3, x6
P 003374b3 and x9, x6, x3
P 00726533 or x10, x4, x7
P 04802023 sw x8, 64(x0)
P 08500593 addi x11, x0, 0x85
P 04b000a3 sb x11, 65(x0)
P 04002603 lw x12, 64(x0)
P 001606b3 add x13, x12, x1
P 04100703 lb x14, 65(x0)
P 04104783 lbu x15, 65(x0)
P 00700013 addi x0, x0, 7
P 00100833 add x16, x0, x1
P 00410463 beq x2, x4, +8
P 00100893 addi x17, x0, 1
P 01009463 bne x1, x16, +8
P 0080096f jal x18, +8
P 00200993 addi x19, x0, 2
P 12345a37 lui x20, 0x12345
P 00001a97 auipc x21, 0x1
P 0000006f jal x0, 0
R 01 00000005
R 02 00000008
R 03 0000000d
R 04 00000008
R 06 ffffffff
R 07 00000001
R 08 fffffff2
R 09 0000000d
R 0a 00000009
R 0b 00000085
R 0c ffff85f2
R 0d ffff85f7
R 0e ffffff85
R 0f 00000085
R 10 00000005
R 12 00000058
R 14 12345000
R 15 00001060

/* list.f */
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/core_top.sv
sim/core_props.sv
sim/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
